// ==== Bender.yml ====
package:
  name: bfly_net

sources:
  - common/bflyPkg.sv
  - design/prioLfsr.sv
  - stage/switchBox2x2.sv
  - stage/bflyStage.sv
  - design/bflyNet.sv
  - target: test
    files:
      - bench/bflyNet_assert.sv
      - bench/bflyNetTb.sv

// ==== bench/bflyNetTb.sv ====
// Butterfly network testbench
`timescale 1ns/1ns
`default_nettype none

module bflyNetTb import bflyPkg::*;;

  localparam int WaitLimit = 20;

  // Signal selectors for the bounded wait
  localparam int SelGnt = 0;
  localparam int SelVld = 1;
  localparam int SelRdy = 2;

  logic                    clk;
  logic                    rstN;
  logic     [NumPorts-1:0] reqIni;
  logic     [NumPorts-1:0] gntIni;
  reqBeatT  [NumPorts-1:0] reqBeat;
  logic     [NumPorts-1:0] vldIni;
  logic     [NumPorts-1:0] rdyIni;
  respDataT [NumPorts-1:0] respData;
  logic     [NumPorts-1:0] reqTgt;
  logic     [NumPorts-1:0] gntTgt;
  reqBeatT  [NumPorts-1:0] tgtBeat;
  logic     [NumPorts-1:0] vldTgt;
  logic     [NumPorts-1:0] rdyTgt;
  respBeatT [NumPorts-1:0] respBeat;

  int unsigned errCount;
  int unsigned checkCount;
  int unsigned testsRun;
  logic [31:0] rngState;

  bflyNet bflyNet_i (
    .clk_i     (clk),
    .rstN_i    (rstN),
    .reqIni_i  (reqIni),
    .gntIni_o  (gntIni),
    .reqBeat_i (reqBeat),
    .vldIni_o  (vldIni),
    .rdyIni_i  (rdyIni),
    .respData_o(respData),
    .reqTgt_o  (reqTgt),
    .gntTgt_i  (gntTgt),
    .reqBeat_o (tgtBeat),
    .vldTgt_i  (vldTgt),
    .rdyTgt_o  (rdyTgt),
    .respBeat_i(respBeat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // LCG for data values and stall patterns
  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  function automatic logic pickBit(input int sel, input int idx);
    case (sel)
      SelGnt:  return gntIni[idx];
      SelVld:  return vldIni[idx];
      default: return rdyTgt[idx];
    endcase
  endfunction

  task automatic checkVal(input string name, input logic [63:0] act, input logic [63:0] exp);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, act, exp);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic nextDrive();
    @(posedge clk);
    #10;
  endtask

  task automatic clearInputs();
    reqIni   = '0;
    reqBeat  = '0;
    gntTgt   = '0;
    vldTgt   = '0;
    rdyIni   = '1;
    respBeat = '0;
  endtask

  // Samples at the falling edge until the bit rises or the limit runs out
  task automatic awaitHigh(input int sel, input int idx, input string what, output bit ok);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!pickBit(sel, idx) && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    ok = pickBit(sel, idx);
    if (!ok) begin
      errCount++;
      $display("Timeout: %s did not rise within %0d cycles", what, WaitLimit);
    end
  endtask

  task automatic reportTest(input string name, input int unsigned errBefore);
    testsRun++;
    $display("Test %s finished with %0d errors", name, errCount - errBefore);
  endtask

  task automatic singleRouting();
    int unsigned errBefore;
    int ini;
    int tgt;
    bit ok;
    reqDataT data;
    errBefore = errCount;
    for (ini = 0; ini < NumPorts; ini++) begin
      for (tgt = 0; tgt < NumPorts; tgt++) begin
        nextDrive();
        clearInputs();
        data = nextRand();
        reqIni[ini] = 1'b1;
        reqBeat[ini].addr = portAddrT'(tgt);
        // Junk index, the network must overwrite it
        reqBeat[ini].iniAddr = portAddrT'(nextRand());
        reqBeat[ini].data = data;
        gntTgt = '1;
        awaitHigh(SelGnt, ini, $sformatf("gntIni_o[%0d]", ini), ok);
        if (ok) begin
          checkVal("reqTgt_o", reqTgt, 64'(1) << tgt);
          checkVal("gntIni_o", gntIni, 64'(1) << ini);
          checkVal($sformatf("reqBeat_o[%0d].data", tgt), tgtBeat[tgt].data, data);
          checkVal($sformatf("reqBeat_o[%0d].iniAddr", tgt), tgtBeat[tgt].iniAddr, ini);
        end
      end
    end
    nextDrive();
    clearInputs();
    reportTest("singleRouting", errBefore);
  endtask

  task automatic responseReturn();
    int unsigned errBefore;
    int ini;
    int tgt;
    bit ok;
    respDataT data;
    errBefore = errCount;
    for (tgt = 0; tgt < NumPorts; tgt++) begin
      for (ini = 0; ini < NumPorts; ini++) begin
        nextDrive();
        clearInputs();
        data = nextRand();
        vldTgt[tgt] = 1'b1;
        respBeat[tgt].iniAddr = portAddrT'(ini);
        respBeat[tgt].data = data;
        awaitHigh(SelVld, ini, $sformatf("vldIni_o[%0d]", ini), ok);
        if (ok) begin
          checkVal("vldIni_o", vldIni, 64'(1) << ini);
          checkVal("rdyTgt_o", rdyTgt, 64'(1) << tgt);
          checkVal($sformatf("respData_o[%0d]", ini), respData[ini], data);
        end
      end
    end
    nextDrive();
    clearInputs();
    reportTest("responseReturn", errBefore);
  endtask

  // Identity or complement mapping, both are their own inverse
  task automatic permutation(input bit complement);
    int unsigned errBefore;
    int i;
    int dst;
    bit ok;
    reqDataT sent [NumPorts];
    errBefore = errCount;
    nextDrive();
    clearInputs();
    for (i = 0; i < NumPorts; i++) begin
      dst = complement ? NumPorts - 1 - i : i;
      sent[i] = nextRand();
      reqIni[i] = 1'b1;
      reqBeat[i].addr = portAddrT'(dst);
      reqBeat[i].data = sent[i];
    end
    gntTgt = '1;
    awaitHigh(SelGnt, 0, "gntIni_o[0]", ok);
    if (ok) begin
      checkVal("gntIni_o", gntIni, {NumPorts{1'b1}});
      checkVal("reqTgt_o", reqTgt, {NumPorts{1'b1}});
      for (i = 0; i < NumPorts; i++) begin
        dst = complement ? NumPorts - 1 - i : i;
        checkVal($sformatf("reqBeat_o[%0d].iniAddr", i), tgtBeat[i].iniAddr, dst);
        checkVal($sformatf("reqBeat_o[%0d].data", i), tgtBeat[i].data, sent[dst]);
      end
    end
    nextDrive();
    clearInputs();
    reportTest(complement ? "permComplement" : "permIdentity", errBefore);
  endtask

  task automatic contention(input int iniA, input int iniB, input int tgt);
    int unsigned errBefore;
    int cnt;
    logic [1:0] pending;
    logic [31:0] stall;
    reqDataT dataA;
    reqDataT dataB;
    errBefore = errCount;
    cnt = 0;
    pending = 2'b11;
    dataA = nextRand();
    dataB = nextRand();
    nextDrive();
    clearInputs();
    reqBeat[iniA].addr = portAddrT'(tgt);
    reqBeat[iniA].data = dataA;
    reqBeat[iniB].addr = portAddrT'(tgt);
    reqBeat[iniB].data = dataB;
    while (pending != 2'b00 && cnt < 4 * WaitLimit) begin
      reqIni[iniA] = pending[0];
      reqIni[iniB] = pending[1];
      // Random target stalls
      stall = nextRand();
      gntTgt[tgt] = stall[12];
      @(negedge clk);
      checkVal("reqTgt_o", reqTgt, 64'(1) << tgt);
      if (gntTgt[tgt]) begin
        checkVal("granted count", $countones(gntIni), 1);
        if (gntIni[iniA]) begin
          checkVal("reqBeat_o.iniAddr", tgtBeat[tgt].iniAddr, iniA);
          checkVal("reqBeat_o.data", tgtBeat[tgt].data, dataA);
          pending[0] = 1'b0;
        end
        if (gntIni[iniB]) begin
          checkVal("reqBeat_o.iniAddr", tgtBeat[tgt].iniAddr, iniB);
          checkVal("reqBeat_o.data", tgtBeat[tgt].data, dataB);
          pending[1] = 1'b0;
        end
      end else begin
        checkVal("granted count under stall", $countones(gntIni), 0);
      end
      nextDrive();
      cnt++;
    end
    if (pending != 2'b00) begin
      errCount++;
      $display("Timeout: contending requests to target %0d were not all granted", tgt);
    end
    clearInputs();
    reportTest($sformatf("contention%0d%0d", iniA, iniB), errBefore);
  endtask

  task automatic backPressure();
    int unsigned errBefore;
    bit ok;
    reqDataT reqData;
    respDataT rspData;
    errBefore = errCount;
    reqData = nextRand();
    rspData = nextRand();
    nextDrive();
    clearInputs();
    reqIni[2] = 1'b1;
    reqBeat[2].addr = portAddrT'(5);
    reqBeat[2].data = reqData;
    repeat (3) begin
      @(negedge clk);
      checkVal("reqTgt_o[5]", reqTgt[5], 1);
      checkVal("reqBeat_o[5].data", tgtBeat[5].data, reqData);
      checkVal("gntIni_o", gntIni, 0);
      nextDrive();
    end
    gntTgt[5] = 1'b1;
    awaitHigh(SelGnt, 2, "gntIni_o[2]", ok);
    if (ok) begin
      checkVal("gntIni_o", gntIni, 64'(1) << 2);
    end
    nextDrive();
    clearInputs();
    rdyIni = '0;
    vldTgt[5] = 1'b1;
    respBeat[5].iniAddr = portAddrT'(2);
    respBeat[5].data = rspData;
    repeat (3) begin
      @(negedge clk);
      checkVal("vldIni_o[2]", vldIni[2], 1);
      checkVal("rdyTgt_o[5]", rdyTgt[5], 0);
      checkVal("respData_o[2]", respData[2], rspData);
      nextDrive();
    end
    rdyIni[2] = 1'b1;
    awaitHigh(SelRdy, 5, "rdyTgt_o[5]", ok);
    if (ok) begin
      checkVal("respData_o[2]", respData[2], rspData);
    end
    nextDrive();
    clearInputs();
    reportTest("backPressure", errBefore);
  endtask

  initial begin
    errCount = 0;
    checkCount = 0;
    testsRun = 0;
    rngState = 32'd88;
    rstN = 1'b0;
    clearInputs();
    repeat (4) @(posedge clk);
    #10;
    rstN = 1'b1;

    singleRouting();
    responseReturn();
    permutation(1'b0);
    permutation(1'b1);
    // Conflicts in the first and in the last stage
    contention(1, 5, 3);
    contention(6, 7, 2);
    backPressure();

    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/bflyNet_assert.sv ====
// Butterfly network protocol assertions
`timescale 1ns/1ns
`default_nettype none

module bflyNetAssert import bflyPkg::*; (
  input logic                    clk_i,
  input logic                    rstN_i,
  input logic     [NumPorts-1:0] reqIni_i,
  input logic     [NumPorts-1:0] gntIni_i,
  input reqBeatT  [NumPorts-1:0] reqBeat_i,
  input logic     [NumPorts-1:0] vldIni_i,
  input logic     [NumPorts-1:0] vldTgt_i,
  input respBeatT [NumPorts-1:0] respBeat_i,
  input logic     [NumPorts-1:0] gntTgt_i,
  input logic     [NumPorts-1:0] reqTgt_i
);

  // Initiators that request a target which grants this cycle
  logic [NumPorts-1:0] gntAllowed;
  // Initiators named by the index of some valid target response
  logic [NumPorts-1:0] vldAddressed;

  always_comb begin
    gntAllowed   = '0;
    vldAddressed = '0;
    for (int p = 0; p < NumPorts; p++) begin
      gntAllowed[p] = reqIni_i[p] && gntTgt_i[reqBeat_i[p].addr];
      if (vldTgt_i[p]) begin
        vldAddressed[respBeat_i[p].iniAddr] = 1'b1;
      end
    end
  end

  // A grant only answers a live request that its target grants
  gntNeedsReq: assert property (
    @(posedge clk_i) disable iff (!rstN_i) (gntIni_i & ~gntAllowed) == '0
  ) else $error("gntIni_o high without reqIni_i or a granting target");

  // Each response comes from a valid target that carries this initiator's index
  vldNeedsTgt: assert property (
    @(posedge clk_i) disable iff (!rstN_i) (vldIni_i & ~vldAddressed) == '0
  ) else $error("vldIni_o high without a matching vldTgt_i");

  noUnknown: assert property (
    @(posedge clk_i) disable iff (!rstN_i) !$isunknown(reqTgt_i) && !$isunknown(vldIni_i)
  ) else $error("reqTgt_o or vldIni_o unknown");

endmodule

bind bflyNet bflyNetAssert bflyNetAssert_i (
  .clk_i     (clk_i),
  .rstN_i    (rstN_i),
  .reqIni_i  (reqIni_i),
  .gntIni_i  (gntIni_o),
  .reqBeat_i (reqBeat_i),
  .vldIni_i  (vldIni_o),
  .vldTgt_i  (vldTgt_i),
  .respBeat_i(respBeat_i),
  .gntTgt_i  (gntTgt_i),
  .reqTgt_i  (reqTgt_o)
);

`default_nettype wire

// ==== common/bflyPkg.sv ====
// Butterfly network definitions
`default_nettype none

package bflyPkg;

  // Network size, fixed for the whole design
  localparam int unsigned NumPorts = 8;

  // One stage per address bit
  localparam int unsigned AddrWidth = $clog2(NumPorts);

  localparam int unsigned ReqDataWidth  = 32;
  localparam int unsigned RespDataWidth = 32;

  // Length of the arbitration priority LFSR
  localparam int unsigned LfsrWidth = 16;

  // Target address or initiator index
  typedef logic [AddrWidth-1:0] portAddrT;

  typedef logic [ReqDataWidth-1:0]  reqDataT;
  typedef logic [RespDataWidth-1:0] respDataT;

  // Request beat
  // addr loses its top bit at every stage, iniAddr gains one
  typedef struct packed {
    portAddrT addr;
    portAddrT iniAddr;
    reqDataT  data;
  } reqBeatT;

  // Response beat
  // iniAddr is consumed from the LSB on the way back
  typedef struct packed {
    portAddrT iniAddr;
    respDataT data;
  } respBeatT;

endpackage

`default_nettype wire

// ==== design/bflyNet.sv ====
// Radix-2 butterfly interconnect
`timescale 1ns/1ns
`default_nettype none

module bflyNet import bflyPkg::*; (
  input  logic                    clk_i,
  input  logic                    rstN_i,
  // Initiator side
  input  logic     [NumPorts-1:0] reqIni_i,
  output logic     [NumPorts-1:0] gntIni_o,
  input  reqBeatT  [NumPorts-1:0] reqBeat_i,
  output logic     [NumPorts-1:0] vldIni_o,
  input  logic     [NumPorts-1:0] rdyIni_i,
  output respDataT [NumPorts-1:0] respData_o,
  // Target side
  output logic     [NumPorts-1:0] reqTgt_o,
  input  logic     [NumPorts-1:0] gntTgt_i,
  output reqBeatT  [NumPorts-1:0] reqBeat_o,
  input  logic     [NumPorts-1:0] vldTgt_i,
  output logic     [NumPorts-1:0] rdyTgt_o,
  input  respBeatT [NumPorts-1:0] respBeat_i
);

  // Signals at each stage boundary
  // Boundary 0 faces the initiators, boundary AddrWidth the targets
  logic     [AddrWidth:0][NumPorts-1:0] req;
  logic     [AddrWidth:0][NumPorts-1:0] gnt;
  reqBeatT  [AddrWidth:0][NumPorts-1:0] beat;
  logic     [AddrWidth:0][NumPorts-1:0] vld;
  logic     [AddrWidth:0][NumPorts-1:0] rdy;
  respBeatT [AddrWidth:0][NumPorts-1:0] resp;

  logic [AddrWidth-1:0] reqPrio;
  logic [AddrWidth-1:0] respPrio;
  logic                 lfsrEn;

  // Initiator ports
  assign req[0]   = reqIni_i;
  assign gntIni_o = gnt[0];
  assign rdy[0]   = rdyIni_i;
  assign vldIni_o = vld[0];

  for (genvar i = 0; i < NumPorts; i++) begin : genIni
    // Index is rebuilt by the stages, start from zero
    assign beat[0][i] = '{addr: reqBeat_i[i].addr, iniAddr: '0, data: reqBeat_i[i].data};
    assign respData_o[i] = resp[0][i].data;
  end

  // Target ports
  assign reqTgt_o        = req[AddrWidth];
  assign gnt[AddrWidth]  = gntTgt_i;
  assign reqBeat_o       = beat[AddrWidth];
  assign vld[AddrWidth]  = vldTgt_i;
  assign rdyTgt_o        = rdy[AddrWidth];
  assign resp[AddrWidth] = respBeat_i;

  // Priorities move on with every accepted request
  assign lfsrEn = |(reqTgt_o & gntTgt_i);

  prioLfsr #(
    .LfsrSeed(16'hACE1)
  ) prioLfsr_i (
    .clk_i     (clk_i),
    .rstN_i    (rstN_i),
    .en_i      (lfsrEn),
    .reqPrio_o (reqPrio),
    .respPrio_o(respPrio)
  );

  for (genvar l = 0; l < AddrWidth; l++) begin : genStage
    // Stage l arbitrates with the bit of the address it steers on
    bflyStage #(
      .StageIdx(l)
    ) stage_i (
      .req_i     (req[l]),
      .gnt_o     (gnt[l]),
      .beat_i    (beat[l]),
      .req_o     (req[l+1]),
      .gnt_i     (gnt[l+1]),
      .beat_o    (beat[l+1]),
      .vld_i     (vld[l+1]),
      .rdy_o     (rdy[l+1]),
      .resp_i    (resp[l+1]),
      .vld_o     (vld[l]),
      .rdy_i     (rdy[l]),
      .resp_o    (resp[l]),
      .reqPrio_i (reqPrio[AddrWidth-1-l]),
      .respPrio_i(respPrio[AddrWidth-1-l])
    );
  end

endmodule

`default_nettype wire

// ==== design/prioLfsr.sv ====
// Arbitration priority LFSR
`timescale 1ns/1ns
`default_nettype none

module prioLfsr import bflyPkg::*; #(
  parameter logic [LfsrWidth-1:0] LfsrSeed = 16'h0001
) (
  input  logic                 clk_i,
  input  logic                 rstN_i,
  input  logic                 en_i,
  output logic [AddrWidth-1:0] reqPrio_o,
  output logic [AddrWidth-1:0] respPrio_o
);

  // Feedback taps for x^16 + x^14 + x^13 + x^11 + 1, maximal length
  localparam logic [LfsrWidth-1:0] FeedbackMask = 16'hB400;

  logic [LfsrWidth-1:0] lfsrQ;
  logic [LfsrWidth-1:0] lfsrD;

  // Galois form, shifts right and folds the dropped bit into the taps
  always_comb begin
    lfsrD = lfsrQ >> 1;
    if (lfsrQ[0]) begin
      lfsrD = lfsrD ^ FeedbackMask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      lfsrQ <= LfsrSeed;
    end else if (en_i) begin
      lfsrQ <= lfsrD;
    end
  end

  // Request and response priorities from opposite ends of the register
  assign reqPrio_o  = lfsrQ[AddrWidth-1:0];
  assign respPrio_o = lfsrQ[LfsrWidth-1 -: AddrWidth];

endmodule

`default_nettype wire

// ==== src.f ====
common/bflyPkg.sv
design/prioLfsr.sv
stage/switchBox2x2.sv
stage/bflyStage.sv
design/bflyNet.sv
bench/bflyNet_assert.sv
bench/bflyNetTb.sv

// ==== stage/bflyStage.sv ====
// Butterfly network stage
`timescale 1ns/1ns
`default_nettype none

module bflyStage import bflyPkg::*; #(
  parameter int unsigned StageIdx = 0
) (
  // Request path
  input  logic     [NumPorts-1:0] req_i,
  output logic     [NumPorts-1:0] gnt_o,
  input  reqBeatT  [NumPorts-1:0] beat_i,
  output logic     [NumPorts-1:0] req_o,
  input  logic     [NumPorts-1:0] gnt_i,
  output reqBeatT  [NumPorts-1:0] beat_o,
  // Response path
  input  logic     [NumPorts-1:0] vld_i,
  output logic     [NumPorts-1:0] rdy_o,
  input  respBeatT [NumPorts-1:0] resp_i,
  output logic     [NumPorts-1:0] vld_o,
  input  logic     [NumPorts-1:0] rdy_i,
  output respBeatT [NumPorts-1:0] resp_o,
  // Priorities for this stage
  input  logic                    reqPrio_i,
  input  logic                    respPrio_i
);

  // Address bit on which this stage pairs its lines
  localparam int unsigned PairBit = AddrWidth - 1 - StageIdx;

  for (genvar k = 0; k < NumPorts/2; k++) begin : genBox
    // Lower line of the pair, k with a zero inserted at PairBit
    localparam int unsigned LineLo = ((k >> PairBit) << (PairBit + 1)) | (k % (1 << PairBit));

    logic     [1:0] boxReq;
    logic     [1:0] boxGnt;
    reqBeatT  [1:0] boxBeat;
    logic     [1:0] boxReqOut;
    logic     [1:0] boxGntIn;
    reqBeatT  [1:0] boxBeatOut;
    logic     [1:0] boxVld;
    logic     [1:0] boxRdy;
    respBeatT [1:0] boxResp;
    logic     [1:0] boxVldOut;
    logic     [1:0] boxRdyIn;
    respBeatT [1:0] boxRespOut;

    // Box port p sits on the line whose PairBit equals p
    for (genvar p = 0; p < 2; p++) begin : genLine
      localparam int unsigned Line = LineLo + p * (1 << PairBit);

      assign boxReq[p]   = req_i[Line];
      assign gnt_o[Line] = boxGnt[p];
      assign boxBeat[p]  = beat_i[Line];

      assign req_o[Line]  = boxReqOut[p];
      assign boxGntIn[p]  = gnt_i[Line];
      assign beat_o[Line] = boxBeatOut[p];

      assign boxVld[p]   = vld_i[Line];
      assign rdy_o[Line] = boxRdy[p];
      assign boxResp[p]  = resp_i[Line];

      assign vld_o[Line]  = boxVldOut[p];
      assign boxRdyIn[p]  = rdy_i[Line];
      assign resp_o[Line] = boxRespOut[p];
    end

    switchBox2x2 box_i (
      .req_i     (boxReq),
      .gnt_o     (boxGnt),
      .beat_i    (boxBeat),
      .req_o     (boxReqOut),
      .gnt_i     (boxGntIn),
      .beat_o    (boxBeatOut),
      .vld_i     (boxVld),
      .rdy_o     (boxRdy),
      .resp_i    (boxResp),
      .vld_o     (boxVldOut),
      .rdy_i     (boxRdyIn),
      .resp_o    (boxRespOut),
      .reqPrio_i (reqPrio_i),
      .respPrio_i(respPrio_i)
    );
  end

endmodule

`default_nettype wire

// ==== stage/switchBox2x2.sv ====
// Full-duplex 2x2 switchbox
`timescale 1ns/1ns
`default_nettype none

module switchBox2x2 import bflyPkg::*; (
  // Request path, upstream side
  input  logic     [1:0] req_i,
  output logic     [1:0] gnt_o,
  input  reqBeatT  [1:0] beat_i,
  // Request path, downstream side
  output logic     [1:0] req_o,
  input  logic     [1:0] gnt_i,
  output reqBeatT  [1:0] beat_o,
  // Response path, downstream side
  input  logic     [1:0] vld_i,
  output logic     [1:0] rdy_o,
  input  respBeatT [1:0] resp_i,
  // Response path, upstream side
  output logic     [1:0] vld_o,
  input  logic     [1:0] rdy_i,
  output respBeatT [1:0] resp_o,
  // Stage priorities
  input  logic           reqPrio_i,
  input  logic           respPrio_i
);

  // Output each request heads for, taken from its top address bit
  logic [1:0] reqDir;
  // Input that currently owns each downstream output
  logic [1:0] reqSel;
  // Upstream port each response heads for
  logic [1:0] respDir;
  // Downstream input that owns each upstream port
  logic [1:0] respSel;

  for (genvar i = 0; i < 2; i++) begin : genDecode
    localparam logic InBit = 1'(i);

    assign reqDir[i]  = beat_i[i].addr[AddrWidth-1];
    // LSB matches the bit this stage inserted on the way out
    assign respDir[i] = resp_i[i].iniAddr[0];

    // Grant only the winner, and only while the next stage grants
    assign gnt_o[i] = req_i[i] && gnt_i[reqDir[i]] && (reqSel[reqDir[i]] == InBit);

    // Ready back to the target side under the same rule
    assign rdy_o[i] = vld_i[i] && rdy_i[respDir[i]] && (respSel[respDir[i]] == InBit);
  end

  // Request steering and arbitration
  for (genvar o = 0; o < 2; o++) begin : genReqOut
    localparam logic OutBit = 1'(o);

    logic [1:0] want;

    assign want[0] = req_i[0] && (reqDir[0] == OutBit);
    assign want[1] = req_i[1] && (reqDir[1] == OutBit);

    // On conflict the line matching the priority bit wins
    assign reqSel[o] = (&want) ? reqPrio_i : want[1];
    assign req_o[o]  = |want;

    // Consume the top address bit, record the input line bit
    assign beat_o[o].addr    = beat_i[reqSel[o]].addr << 1;
    assign beat_o[o].iniAddr = {beat_i[reqSel[o]].iniAddr[AddrWidth-2:0], reqSel[o]};
    assign beat_o[o].data    = beat_i[reqSel[o]].data;
  end

  // Response steering, mirror image of the request side
  for (genvar u = 0; u < 2; u++) begin : genRespOut
    localparam logic UpBit = 1'(u);

    logic [1:0] want;

    assign want[0] = vld_i[0] && (respDir[0] == UpBit);
    assign want[1] = vld_i[1] && (respDir[1] == UpBit);

    assign respSel[u] = (&want) ? respPrio_i : want[1];
    assign vld_o[u]   = |want;

    // Drop the index bit used here
    assign resp_o[u].iniAddr = resp_i[respSel[u]].iniAddr >> 1;
    assign resp_o[u].data    = resp_i[respSel[u]].data;
  end

endmodule

`default_nettype wire
